//--- verilog/isa_pkg.sv
// Fixed 16-bit words and byte addresses. Only the halt and no-op opcodes are decoded here.
package isa_pkg;

    // instruction and data word width
    localparam int WORD_W = 16;

    // byte address width
    localparam int ADDR_W = 16;

    // opcode field sits in the upper four bits of the word
    localparam int OPCODE_W = 4;

    // only the encodings the fetch stage cares about
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP  = 4'd0,
        OP_HALT = 4'd15
    } opcode_e;

    // bubble issued while no valid instruction is available
    localparam logic [WORD_W-1:0] NOP_WORD = '0;

endpackage

//--- verilog/icache_pkg.sv
// Direct-mapped geometry for 16-bit byte addresses. Changing one field needs the others to match.
package icache_pkg;

    // words in one cache block
    localparam int BLOCK_WORDS = 8;

    // number of cache lines
    localparam int NUM_LINES = 8;

    // address split is tag | index | byte offset
    localparam int OFFSET_W = 4;
    localparam int INDEX_W = 3;
    localparam int TAG_W = 9;

    // word select within a block
    localparam int WORD_SEL_W = 3;

    // states of the refill controller
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT,
        DRAIN
    } fill_state_e;

endpackage

//--- verilog/fill_if.sv
// Writes target the line indexed by the current fetch address, so the PC must hold during a fill.
`timescale 1ns/1ps

interface fill_if;

    // lookup side
    logic                            miss;
    logic [isa_pkg::ADDR_W-1:0]      fill_base;

    // refill side
    logic                            write_data;
    logic [icache_pkg::WORD_SEL_W-1:0] write_word;
    logic [isa_pkg::WORD_W-1:0]      write_value;
    logic                            write_tag;

    modport ctrl (
        input  miss, fill_base,
        output write_data, write_word, write_value, write_tag
    );

    modport array (
        output miss, fill_base,
        input  write_data, write_word, write_value, write_tag
    );

endinterface

//--- verilog/fetch_pc.sv
// The halt check trusts instr_i only when the lookup hits. Bubbles decode as no-ops.
`timescale 1ns/1ps

module fetch_pc (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       freeze_i,
    input  logic                       busy_i,
    input  logic [1:0]                 branch_i,
    input  logic                       taken_i,
    input  logic [isa_pkg::ADDR_W-1:0] target_i,
    input  logic [isa_pkg::WORD_W-1:0] instr_i,
    output logic [isa_pkg::ADDR_W-1:0] pc_o,
    output logic [isa_pkg::ADDR_W-1:0] pc_plus2_o,
    output logic                       flush_o
);

    logic [isa_pkg::ADDR_W-1:0] pc_q;
    logic [isa_pkg::ADDR_W-1:0] pc_next;
    isa_pkg::opcode_e           opcode;
    logic                       halt;

    // any branch type with a taken result redirects the stage
    assign flush_o = (branch_i != 2'b00) && taken_i;

    assign opcode = isa_pkg::opcode_e'(instr_i[isa_pkg::WORD_W-1 -: isa_pkg::OPCODE_W]);
    assign halt = (opcode == isa_pkg::OP_HALT);

    assign pc_plus2_o = pc_q + isa_pkg::ADDR_W'(2);

    // hold beats redirect, redirect beats halt
    always_comb begin
        if (busy_i || freeze_i) begin
            pc_next = pc_q;
        end else if (flush_o) begin
            pc_next = target_i;
        end else if (halt) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_plus2_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- verilog/icache_array.sv
// Direct-mapped and read-only. Fill writes use the index of addr_i, which must stay put until the tag is written.
`timescale 1ns/1ps

module icache_array (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       enable_i,
    input  logic [isa_pkg::ADDR_W-1:0] addr_i,
    fill_if.array                      fill,
    output logic [isa_pkg::WORD_W-1:0] instr_o,
    output logic                       hit_o
);

    logic [icache_pkg::NUM_LINES-1:0] valid_q;
    logic [icache_pkg::TAG_W-1:0]     tag_mem [icache_pkg::NUM_LINES];
    logic [isa_pkg::WORD_W-1:0]       data_mem [icache_pkg::NUM_LINES*icache_pkg::BLOCK_WORDS];

    logic [icache_pkg::TAG_W-1:0]      addr_tag;
    logic [icache_pkg::INDEX_W-1:0]    addr_index;
    logic [icache_pkg::WORD_SEL_W-1:0] addr_word;
    logic                              tag_match;

    // split the fetch address, bit 0 is always zero for 16-bit words
    assign addr_tag = addr_i[isa_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign addr_index = addr_i[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign addr_word = addr_i[1 +: icache_pkg::WORD_SEL_W];

    assign tag_match = valid_q[addr_index] && (tag_mem[addr_index] == addr_tag);

    // lookup is gated by enable
    assign hit_o = enable_i && tag_match;
    assign fill.miss = enable_i && !tag_match;

    assign fill.fill_base = {addr_i[isa_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                             {icache_pkg::OFFSET_W{1'b0}}};

    assign instr_o = hit_o ? data_mem[{addr_index, addr_word}] : isa_pkg::NOP_WORD;

    // line goes invalid on its first refill word so an aborted fill leaves no stale hit
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill.write_tag) begin
            valid_q[addr_index] <= 1'b1;
        end else if (fill.write_data) begin
            valid_q[addr_index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.write_tag) begin
            tag_mem[addr_index] <= addr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.write_data) begin
            data_mem[{addr_index, fill.write_word}] <= fill.write_value;
        end
    end

endmodule

//--- verilog/fill_word_counter.sv
// Counts up to one block. Clear wins over advance when both arrive together.
`timescale 1ns/1ps

module fill_word_counter (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              clear_i,
    input  logic                              advance_i,
    output logic [icache_pkg::WORD_SEL_W-1:0] count_o,
    output logic                              last_o
);

    logic [icache_pkg::WORD_SEL_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (advance_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;

    // final word of the block
    assign last_o = (count_q == icache_pkg::WORD_SEL_W'(icache_pkg::BLOCK_WORDS - 1));

endmodule

//--- verilog/cache_fill_fsm.sv
// One memory read outstanding at a time. A redirect aborts the fill and any owed response is dropped.
`timescale 1ns/1ps

module cache_fill_fsm (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    fill_if.ctrl                       fill,
    input  logic [isa_pkg::WORD_W-1:0] mem_data_i,
    input  logic                       mem_valid_i,
    output logic                       mem_rd_o,
    output logic [isa_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                       busy_o
);

    icache_pkg::fill_state_e state_q;
    icache_pkg::fill_state_e state_next;

    logic [icache_pkg::WORD_SEL_W-1:0] word_count;
    logic                              last_word;
    logic                              word_done;

    // response for the current word, not cancelled by a redirect
    assign word_done = (state_q == icache_pkg::WAIT) && mem_valid_i && !flush_i;

    fill_word_counter i_word_counter (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .clear_i   (flush_i || fill.write_tag),
        .advance_i (fill.write_data),
        .count_o   (word_count),
        .last_o    (last_word)
    );

    always_comb begin
        state_next = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (fill.miss) begin
                    state_next = icache_pkg::REQUEST;
                end
            end
            icache_pkg::REQUEST: begin
                // nothing issued yet, so a redirect can drop straight out
                state_next = flush_i ? icache_pkg::IDLE : icache_pkg::WAIT;
            end
            icache_pkg::WAIT: begin
                if (mem_valid_i) begin
                    if (flush_i || last_word) begin
                        state_next = icache_pkg::IDLE;
                    end else begin
                        state_next = icache_pkg::REQUEST;
                    end
                end else if (flush_i) begin
                    state_next = icache_pkg::DRAIN;
                end
            end
            icache_pkg::DRAIN: begin
                if (mem_valid_i) begin
                    state_next = icache_pkg::IDLE;
                end
            end
            default: state_next = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    assign mem_rd_o = (state_q == icache_pkg::REQUEST) && !flush_i;
    assign mem_addr_o = fill.fill_base + isa_pkg::ADDR_W'({word_count, 1'b0});
    assign busy_o = (state_q != icache_pkg::IDLE);

    // array writes land in the response cycle
    assign fill.write_data = word_done;
    assign fill.write_word = word_count;
    assign fill.write_value = mem_data_i;
    assign fill.write_tag = word_done && last_word;

endmodule

//--- verilog/fetch_stage.sv
// No decode and no IF/ID register. instr_o is a bubble whenever instr_valid_o is low.
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       freeze_i,
    input  logic [1:0]                 branch_i,
    input  logic                       taken_i,
    input  logic [isa_pkg::ADDR_W-1:0] target_i,
    input  logic [isa_pkg::WORD_W-1:0] mem_data_i,
    input  logic                       mem_valid_i,
    output logic [isa_pkg::ADDR_W-1:0] pc_o,
    output logic [isa_pkg::ADDR_W-1:0] pc_plus2_o,
    output logic [isa_pkg::WORD_W-1:0] instr_o,
    output logic                       instr_valid_o,
    output logic                       busy_o,
    output logic                       mem_rd_o,
    output logic [isa_pkg::ADDR_W-1:0] mem_addr_o
);

    fill_if fill_bus ();

    logic flush;
    logic hit;
    logic stall;
    logic lookup_en;

    // PC also waits out the miss cycle before busy rises
    assign stall = busy_o || fill_bus.miss;

    // no lookup on a redirect
    assign lookup_en = !flush;

    assign instr_valid_o = hit;

    fetch_pc i_fetch_pc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .freeze_i   (freeze_i),
        .busy_i     (stall),
        .branch_i   (branch_i),
        .taken_i    (taken_i),
        .target_i   (target_i),
        .instr_i    (instr_o),
        .pc_o       (pc_o),
        .pc_plus2_o (pc_plus2_o),
        .flush_o    (flush)
    );

    icache_array i_icache_array (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .enable_i (lookup_en),
        .addr_i   (pc_o),
        .fill     (fill_bus.array),
        .instr_o  (instr_o),
        .hit_o    (hit)
    );

    cache_fill_fsm i_cache_fill_fsm (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush),
        .fill        (fill_bus.ctrl),
        .mem_data_i  (mem_data_i),
        .mem_valid_i (mem_valid_i),
        .mem_rd_o    (mem_rd_o),
        .mem_addr_o  (mem_addr_o),
        .busy_o      (busy_o)
    );

endmodule

//--- verification/fetch_stage_properties.sv
// Bound into the fill controller. Needs a simulator with concurrent assertion support.
`timescale 1ns/1ps

module fetch_stage_properties (
    input logic clk,
    input logic rst_n_i,
    input logic rd_strobe_i,
    input logic mem_valid_i,
    input logic busy_i,
    input logic write_data_i,
    input logic write_tag_i
);

    logic       outstanding_q;
    logic [3:0] words_q;

    // one read in flight between strobe and response
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (rd_strobe_i) begin
            outstanding_q <= 1'b1;
        end else if (mem_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    // data writes since the controller last sat idle
    always_ff @(posedge clk) begin
        if (!rst_n_i || !busy_i) begin
            words_q <= '0;
        end else if (write_data_i) begin
            words_q <= words_q + 1'b1;
        end
    end

    rd_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_strobe_i |=> !rd_strobe_i)
        else $error("read strobe held for more than one cycle");

    rd_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding_q |-> !rd_strobe_i)
        else $error("new read while a request is outstanding");

    idle_after_reset: assert property (@(posedge clk) !rst_n_i |=> !busy_i)
        else $error("busy high after reset");

    tag_on_last_word: assert property (@(posedge clk) disable iff (!rst_n_i)
        write_tag_i |-> (write_data_i && words_q == 4'(icache_pkg::BLOCK_WORDS - 1)))
        else $error("tag written without a last-word data write");

endmodule

bind cache_fill_fsm fetch_stage_properties i_fill_props (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rd_strobe_i  (mem_rd_o),
    .mem_valid_i  (mem_valid_i),
    .busy_i       (busy_o),
    .write_data_i (fill.write_data),
    .write_tag_i  (fill.write_tag)
);

//--- verification/tb_fetch_stage.sv
// Memory model serves one read at a time after 1 to 6 cycles. Halt words exist only where planted.
`timescale 1ns/1ps

module tb_fetch_stage;

    localparam logic [15:0] HALT_ADDR = 16'h5008;
    localparam int TIMEOUT = 3000;

    logic        clk = 1'b0;
    logic        rst_n_i = 1'b0;
    logic        freeze_i = 1'b0;
    logic [1:0]  branch_i = 2'b00;
    logic        taken_i = 1'b0;
    logic [15:0] target_i = 16'h0000;
    logic [15:0] mem_data_i = 16'h0000;
    logic        mem_valid_i = 1'b0;
    logic [15:0] pc_o;
    logic [15:0] pc_plus2_o;
    logic [15:0] instr_o;
    logic        instr_valid_o;
    logic        busy_o;
    logic        mem_rd_o;
    logic [15:0] mem_addr_o;

    // memory contents, one entry per 16-bit word
    logic [15:0] mem [32768];
    logic [31:0] rng_state = 32'd40;
    // latency stream of its own for the memory model
    logic [31:0] lat_state = 32'd40;

    // reference model
    logic [15:0] m_pc = 16'h0000;
    logic [7:0]  m_valid = 8'h00;
    logic [8:0]  m_tag [8];
    logic        m_busy = 1'b0;
    logic [15:0] miss_base = 16'h0000;
    logic [15:0] req_addr = 16'h0000;
    logic        outstanding = 1'b0;
    logic        aborted = 1'b0;
    logic        checking = 1'b0;
    int          m_words = 0;
    int          rd_count = 0;
    int          rd_served = 0;
    int          resp_cnt = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    fetch_stage i_fetch_stage (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        state = x;
        return x;
    endfunction

    task automatic expect_value(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0d ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // memory responds a random number of cycles after each read strobe
    always @(posedge clk) begin
        mem_valid_i <= 1'b0;
        if (resp_cnt == 1) begin
            mem_valid_i <= 1'b1;
            mem_data_i <= mem[req_addr[15:1]];
        end
        if (resp_cnt > 0) begin
            resp_cnt--;
        end
        if (rd_count != rd_served) begin
            rd_served = rd_count;
            resp_cnt = 1 + int'(next_rand(lat_state) % 32'd6);
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        logic        flush;
        logic        hit;
        logic        exp_valid;
        logic        exp_miss;
        logic        req_state;
        logic        done;
        logic [2:0]  idx;
        logic [15:0] word;
        if (checking) begin
            flush = (branch_i != 2'b00) && taken_i;
            idx = m_pc[6:4];
            hit = m_valid[idx] && (m_tag[idx] == m_pc[15:7]);
            exp_valid = hit && !flush && !m_busy;
            exp_miss = !hit && !flush && !m_busy;
            // a fill sits in its request cycle when nothing is owed
            req_state = m_busy && !outstanding && !aborted;
            done = 1'b0;
            word = exp_valid ? mem[m_pc[15:1]] : 16'h0000;
            expect_value("pc_o", pc_o, m_pc);
            expect_value("pc_plus2_o", pc_plus2_o, m_pc + 16'd2);
            expect_value("instr_valid_o", 16'(instr_valid_o), 16'(exp_valid));
            expect_value("instr_o", instr_o, word);
            expect_value("busy_o", 16'(busy_o), 16'(m_busy));
            expect_value("mem_rd_o", 16'(mem_rd_o), 16'(req_state && !flush));
            if (mem_rd_o) begin
                expect_value("mem_addr_o", mem_addr_o, miss_base + 16'(2 * m_words));
                outstanding = 1'b1;
                req_addr = mem_addr_o;
                rd_count++;
            end
            if (mem_valid_i) begin
                outstanding = 1'b0;
                done = aborted || flush;
                if (aborted) begin
                    aborted = 1'b0;
                end else if (!flush) begin
                    // line stays invalid until its last word lands
                    m_valid[miss_base[6:4]] = 1'b0;
                    m_words++;
                    if (m_words == 8) begin
                        m_valid[miss_base[6:4]] = 1'b1;
                        m_tag[miss_base[6:4]] = miss_base[15:7];
                        m_words = 0;
                        done = 1'b1;
                    end
                end
            end else if (flush && outstanding) begin
                aborted = 1'b1;
            end
            // redirect before the strobe ends the fill at once
            if (req_state && flush) begin
                done = 1'b1;
            end
            if (flush) begin
                m_words = 0;
            end
            if (exp_miss) begin
                miss_base = {m_pc[15:4], 4'h0};
            end
            // next PC, hold first, then redirect, then halt
            if (!(m_busy || freeze_i || exp_miss)) begin
                if (flush) begin
                    m_pc = target_i;
                end else if (!(exp_valid
                        && isa_pkg::opcode_e'(word[15:12]) == isa_pkg::OP_HALT)) begin
                    m_pc = m_pc + 16'd2;
                end
            end
            m_busy = m_busy ? !done : exp_miss;
        end
    end

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_pc(input logic [15:0] addr);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (pc_o == addr) break;
        end
        if (n == TIMEOUT) begin
            $display("timeout: pc_o never reached %h", addr);
            errors++;
        end
    endtask

    task automatic wait_for(input string name, input logic want_read, input logic level);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if ((want_read ? mem_rd_o : busy_o) == level) break;
        end
        if (n == TIMEOUT) begin
            $display("timeout: %s never went to %0b", name, level);
            errors++;
        end
    endtask

    // hold a taken branch until the stage is free to take it
    task automatic redirect(input logic [15:0] target);
        int n;
        @(posedge clk);
        branch_i <= 2'(32'd1 + next_rand(rng_state) % 32'd3);
        taken_i <= 1'b1;
        target_i <= target;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (!busy_o) break;
        end
        if (n == TIMEOUT) begin
            $display("timeout: redirect to %h was never accepted", target);
            errors++;
        end
        @(posedge clk);
        branch_i <= 2'b00;
        taken_i <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] w;
        int e;
        int k;
        for (int i = 0; i < 32768; i++) begin
            r = next_rand(rng_state);
            w = r[15:0] ^ 16'(i);
            // keep random words away from the halt opcode
            if (w[15:12] == 4'hF) begin
                w[15] = 1'b0;
            end
            mem[i] = w;
        end
        mem[HALT_ADDR[15:1]] = {isa_pkg::OP_HALT, 12'h000};
        run_cycles(4);
        rst_n_i <= 1'b1;
        checking <= 1'b1;

        e = errors;
        wait_pc(16'h0040);
        expect_value("read count", 16'(rd_count), 16'd32);
        finish_test("sequential fetch", e);

        e = errors;
        redirect(16'h0000);
        k = rd_count;
        wait_pc(16'h003E);
        expect_value("reads on rerun", 16'(rd_count - k), 16'd0);
        finish_test("cached rerun", e);

        e = errors;
        for (int i = 0; i < 12; i++) begin
            // branch type without taken must not redirect
            @(posedge clk);
            branch_i <= 2'(32'd1 + next_rand(rng_state) % 32'd3);
            target_i <= 16'(next_rand(rng_state)) & 16'hFFFE;
            run_cycles(1 + int'(next_rand(rng_state) % 32'd3));
            redirect(16'(next_rand(rng_state)) & 16'hFFFE);
            run_cycles(4 + int'(next_rand(rng_state) % 32'd20));
        end
        finish_test("random branches", e);

        e = errors;
        redirect(16'h9000);
        freeze_i <= 1'b1;
        wait_for("busy_o", 1'b0, 1'b1);
        wait_for("busy_o", 1'b0, 1'b0);
        run_cycles(1 + int'(next_rand(rng_state) % 32'd8));
        freeze_i <= 1'b0;
        for (int i = 0; i < 6; i++) begin
            run_cycles(2 + int'(next_rand(rng_state) % 32'd10));
            freeze_i <= 1'b1;
            run_cycles(1 + int'(next_rand(rng_state) % 32'd15));
            freeze_i <= 1'b0;
        end
        finish_test("freeze", e);

        e = errors;
        redirect(16'h5000);
        wait_pc(HALT_ADDR);
        run_cycles(20);
        @(negedge clk);
        expect_value("pc_o at halt", pc_o, HALT_ADDR);
        redirect(16'h5010);
        wait_pc(16'h5014);
        finish_test("halt", e);

        e = errors;
        redirect(16'hA000);
        wait_for("mem_rd_o", 1'b1, 1'b1);
        redirect(16'hB000);
        wait_pc(16'hB010);
        finish_test("redirect during fill", e);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/isa_pkg.sv
verilog/icache_pkg.sv
verilog/fill_if.sv
verilog/fetch_pc.sv
verilog/icache_array.sv
verilog/fill_word_counter.sv
verilog/cache_fill_fsm.sv
verilog/fetch_stage.sv
verification/fetch_stage_properties.sv
verification/tb_fetch_stage.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_fetch_stage -f flist.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_fetch_stage > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0
